/* ow_bus_pkg.sv */
// 1-Wire bus level definitions shared by the bit master and the slave model
// Timing is standard speed only and given in microseconds
// Overdrive and strong pull-up are not covered
package ow_bus_pkg;

    // ====================
    // Bit master FSM
    typedef enum logic [3:0] {
        OW_SLOT_IDLE        = 4'd0,
        OW_SLOT_RESET_LOW   = 4'd1,
        OW_SLOT_RESET_WAIT  = 4'd2,
        OW_SLOT_PRESENCE    = 4'd3,  // Presence sample window
        OW_SLOT_RESET_REC   = 4'd4,
        OW_SLOT_WRITE_LOW   = 4'd5,
        OW_SLOT_WRITE_REC   = 4'd6,
        OW_SLOT_READ_LOW    = 4'd7,
        OW_SLOT_READ_SAMPLE = 4'd8,
        OW_SLOT_READ_REC    = 4'd9
    } ow_slot_state_e;

    // Byte engine to bit master command
    typedef enum logic [1:0] {
        OW_BIT_NONE  = 2'd0,
        OW_BIT_RESET = 2'd1,
        OW_BIT_WRITE = 2'd2,
        OW_BIT_READ  = 2'd3
    } ow_bit_op_e;

    // ====================
    // Slot timing, microseconds
    localparam int OW_T_RESET_LOW_US   = 480;
    localparam int OW_T_RESET_WAIT_US  = 70;   // Release to presence sample
    localparam int OW_T_PRESENCE_US    = 8;
    localparam int OW_T_RESET_REC_US   = 40;
    localparam int OW_T_WRITE0_LOW_US  = 60;
    localparam int OW_T_WRITE1_LOW_US  = 6;
    localparam int OW_T_SLOT_US        = 65;   // Full write or read slot
    localparam int OW_T_READ_LOW_US    = 6;
    localparam int OW_T_READ_SAMPLE_US = 9;    // Low end to sample point
    localparam int OW_T_READ_REC_US    = 55;

endpackage

/* ow_host_pkg.sv */
// Host side definitions for the 1-Wire byte engine
// Opcodes carry no device command knowledge
// CRC is the reflected Dallas/Maxim CRC-8 shifted LSB first
package ow_host_pkg;

    // ====================
    // Host opcodes
    typedef enum logic [1:0] {
        OW_CMD_RESET      = 2'd0,  // Bus reset and presence check
        OW_CMD_WRITE_BYTE = 2'd1,
        OW_CMD_READ_BYTE  = 2'd2,
        OW_CMD_NOP        = 2'd3   // Completes at once, no bus activity
    } ow_cmd_e;

    // ====================
    // Byte engine FSM
    typedef enum logic [1:0] {
        OW_BYTE_IDLE  = 2'd0,
        OW_BYTE_ISSUE = 2'd1,  // Drive bit_op for one cycle
        OW_BYTE_WAIT  = 2'd2   // Wait for bit_done
    } ow_byte_state_e;

    // ====================
    // CRC-8, x^8 + x^5 + x^4 + 1 reflected
    localparam logic [7:0] OW_CRC_POLY = 8'h8C;

endpackage

/* one_wire_master.sv */
// Bit level 1-Wire master for reset/presence, write and read slots
// CLK_FREQ must be a whole number of MHz and at least 1 MHz
// Bus is pulled low or released, never driven high; pull-up is external
// bit_op is only honoured while idle
module one_wire_master import ow_bus_pkg::*; #(
    parameter int CLK_FREQ = 25_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ow_bit_op_e bit_op,            // One-cycle command
    input  logic       bit_wdata,         // Latched at slot start
    output logic       busy,
    output logic       bit_done,          // One-cycle pulse after the slot
    output logic       bit_rdata,
    output logic       presence_detected,
    inout  wire        onewire_io
);

    // ====================
    // Slot timing in cycles
    localparam int CYC_PER_US = CLK_FREQ / 1_000_000;

    // Read recovery trimmed so a read keeps the nominal slot length
    localparam int RD_REC_MAX_US = OW_T_SLOT_US - OW_T_READ_LOW_US - OW_T_READ_SAMPLE_US;
    localparam int RD_REC_US     = (OW_T_READ_REC_US < RD_REC_MAX_US) ?
                                   OW_T_READ_REC_US : RD_REC_MAX_US;

    // End points counted from slot start
    localparam int RST_LOW_END  = OW_T_RESET_LOW_US * CYC_PER_US;
    localparam int RST_WAIT_END = RST_LOW_END + OW_T_RESET_WAIT_US * CYC_PER_US;
    localparam int RST_PRES_END = RST_WAIT_END + OW_T_PRESENCE_US * CYC_PER_US;
    localparam int RST_END      = RST_PRES_END + OW_T_RESET_REC_US * CYC_PER_US;
    localparam int WR0_LOW_END  = OW_T_WRITE0_LOW_US * CYC_PER_US;
    localparam int WR1_LOW_END  = OW_T_WRITE1_LOW_US * CYC_PER_US;
    localparam int SLOT_END     = OW_T_SLOT_US * CYC_PER_US;
    localparam int RD_LOW_END   = OW_T_READ_LOW_US * CYC_PER_US;
    localparam int RD_SMP_END   = RD_LOW_END + OW_T_READ_SAMPLE_US * CYC_PER_US;
    localparam int RD_END       = RD_SMP_END + RD_REC_US * CYC_PER_US;

    // Reset is the longest slot
    localparam int TIMER_W = $clog2(RST_END);

    // Last cycle of each phase
    localparam logic [TIMER_W-1:0] RST_LOW_LAST  = TIMER_W'(RST_LOW_END - 1);
    localparam logic [TIMER_W-1:0] RST_WAIT_LAST = TIMER_W'(RST_WAIT_END - 1);
    localparam logic [TIMER_W-1:0] RST_PRES_LAST = TIMER_W'(RST_PRES_END - 1);
    localparam logic [TIMER_W-1:0] RST_LAST      = TIMER_W'(RST_END - 1);
    localparam logic [TIMER_W-1:0] WR0_LOW_LAST  = TIMER_W'(WR0_LOW_END - 1);
    localparam logic [TIMER_W-1:0] WR1_LOW_LAST  = TIMER_W'(WR1_LOW_END - 1);
    localparam logic [TIMER_W-1:0] SLOT_LAST     = TIMER_W'(SLOT_END - 1);
    localparam logic [TIMER_W-1:0] RD_LOW_LAST   = TIMER_W'(RD_LOW_END - 1);
    localparam logic [TIMER_W-1:0] RD_SMP_LAST   = TIMER_W'(RD_SMP_END - 1);
    localparam logic [TIMER_W-1:0] RD_LAST       = TIMER_W'(RD_END - 1);

    ow_slot_state_e     state;
    logic [TIMER_W-1:0] timer;  // Cycles since slot start, never cleared mid-slot
    logic               oe;     // 1 pulls the bus low
    logic               wbit;   // Bit of the running write slot

    // Open drain
    assign onewire_io = oe ? 1'b0 : 1'bz;
    assign busy       = (state != OW_SLOT_IDLE);

    // ====================
    // Slot FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= OW_SLOT_IDLE;
            timer             <= '0;
            oe                <= 1'b0;
            wbit              <= 1'b0;
            bit_done          <= 1'b0;
            bit_rdata         <= 1'b0;
            presence_detected <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            timer    <= timer + 1'b1;
            case (state)
                OW_SLOT_IDLE: begin
                    timer <= '0;  // First slot cycle sees zero
                    case (bit_op)
                        OW_BIT_RESET: begin
                            state             <= OW_SLOT_RESET_LOW;
                            oe                <= 1'b1;
                            presence_detected <= 1'b0;  // Fresh result per reset
                        end
                        OW_BIT_WRITE: begin
                            state <= OW_SLOT_WRITE_LOW;
                            oe    <= 1'b1;
                            wbit  <= bit_wdata;
                        end
                        OW_BIT_READ: begin
                            state <= OW_SLOT_READ_LOW;
                            oe    <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                OW_SLOT_RESET_LOW: begin
                    if (timer == RST_LOW_LAST) begin
                        state <= OW_SLOT_RESET_WAIT;
                        oe    <= 1'b0;  // Release, slave answers
                    end
                end
                OW_SLOT_RESET_WAIT: begin
                    if (timer == RST_WAIT_LAST) state <= OW_SLOT_PRESENCE;
                end
                OW_SLOT_PRESENCE: begin
                    if (!onewire_io) presence_detected <= 1'b1;  // Any low cycle counts
                    if (timer == RST_PRES_LAST) state <= OW_SLOT_RESET_REC;
                end
                OW_SLOT_RESET_REC: begin
                    if (timer == RST_LAST) begin
                        state    <= OW_SLOT_IDLE;
                        bit_done <= 1'b1;
                    end
                end
                OW_SLOT_WRITE_LOW: begin
                    // Short low for a 1, nearly the whole slot for a 0
                    if (timer == (wbit ? WR1_LOW_LAST : WR0_LOW_LAST)) begin
                        state <= OW_SLOT_WRITE_REC;
                        oe    <= 1'b0;
                    end
                end
                OW_SLOT_WRITE_REC: begin
                    if (timer == SLOT_LAST) begin
                        state    <= OW_SLOT_IDLE;
                        bit_done <= 1'b1;
                    end
                end
                OW_SLOT_READ_LOW: begin
                    if (timer == RD_LOW_LAST) begin
                        state <= OW_SLOT_READ_SAMPLE;
                        oe    <= 1'b0;
                    end
                end
                OW_SLOT_READ_SAMPLE: begin
                    if (timer == RD_SMP_LAST) begin
                        bit_rdata <= onewire_io;  // Single sample at window end
                        state     <= OW_SLOT_READ_REC;
                    end
                end
                OW_SLOT_READ_REC: begin
                    if (timer == RD_LAST) begin
                        state    <= OW_SLOT_IDLE;
                        bit_done <= 1'b1;
                    end
                end
                default: begin
                    state <= OW_SLOT_IDLE;
                    oe    <= 1'b0;
                end
            endcase
        end
    end

    // ====================
    // Checks
    a_bus_free_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == OW_SLOT_IDLE) |-> !oe);
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bit_done |=> !bit_done);
    a_no_op_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (bit_op == OW_BIT_NONE));

endmodule

/* ow_byte_engine.sv */
// Byte sequencer on top of the 1-Wire bit master
// Bytes go out and come in LSB first as eight bit slots
// Running CRC-8 covers every data bit since the last bus reset
// Commands strobed while busy are dropped, there is no queue
module ow_byte_engine import ow_bus_pkg::*, ow_host_pkg::*; #(
    parameter int CLK_FREQ = 25_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_valid,  // One-cycle strobe
    input  ow_cmd_e    cmd_op,
    input  logic [7:0] cmd_data,
    output logic       busy,
    output logic       done,       // One-cycle pulse, busy already low
    output logic [7:0] rd_data,
    output logic       presence,
    output logic [7:0] crc,
    inout  wire        onewire_io
);

    ow_byte_state_e state;
    ow_bit_op_e     slot_op;     // Slot kind repeated for the command
    ow_bit_op_e     bit_op;
    logic           bit_wdata;
    logic           bit_busy;
    logic           bit_done;
    logic           bit_rdata;
    logic           bit_presence;
    logic [2:0]     bit_cnt;
    logic [7:0]     shreg;       // Write data out, read data in
    logic           accept;
    logic           bus_bit;     // Bit that went over the bus this slot
    logic           last_slot;
    logic           data_done;   // A data slot just finished

    // One CRC-8 step, LSB first
    function automatic logic [7:0] crc8_step(input logic [7:0] c, input logic b);
        logic fb;
        fb = c[0] ^ b;
        return (c >> 1) ^ (fb ? OW_CRC_POLY : 8'h00);
    endfunction

    assign accept    = cmd_valid && !busy;
    assign bit_wdata = shreg[0];
    assign bus_bit   = (slot_op == OW_BIT_READ) ? bit_rdata : shreg[0];
    assign last_slot = (slot_op == OW_BIT_RESET) || (bit_cnt == 3'd7);
    assign data_done = (state == OW_BYTE_WAIT) && bit_done && (slot_op != OW_BIT_RESET);
    assign bit_op    = (state == OW_BYTE_ISSUE && !bit_busy) ? slot_op : OW_BIT_NONE;

    // ====================
    // Command FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= OW_BYTE_IDLE;
            slot_op  <= OW_BIT_NONE;
            bit_cnt  <= 3'd0;
            busy     <= 1'b0;
            done     <= 1'b0;
            rd_data  <= 8'h00;
            presence <= 1'b0;
            crc      <= 8'h00;
        end else begin
            done <= 1'b0;
            case (state)
                OW_BYTE_IDLE: begin
                    if (accept) begin
                        bit_cnt <= 3'd0;
                        case (cmd_op)
                            OW_CMD_RESET: begin
                                slot_op <= OW_BIT_RESET;
                                crc     <= 8'h00;  // New transaction
                                state   <= OW_BYTE_ISSUE;
                                busy    <= 1'b1;
                            end
                            OW_CMD_WRITE_BYTE: begin
                                slot_op <= OW_BIT_WRITE;
                                state   <= OW_BYTE_ISSUE;
                                busy    <= 1'b1;
                            end
                            OW_CMD_READ_BYTE: begin
                                slot_op <= OW_BIT_READ;
                                state   <= OW_BYTE_ISSUE;
                                busy    <= 1'b1;
                            end
                            OW_CMD_NOP: done <= 1'b1;  // Results untouched
                        endcase
                    end
                end
                OW_BYTE_ISSUE: begin
                    if (!bit_busy) state <= OW_BYTE_WAIT;  // bit_op seen this cycle
                end
                OW_BYTE_WAIT: begin
                    if (bit_done) begin
                        if (slot_op == OW_BIT_RESET) begin
                            presence <= bit_presence;
                        end else begin
                            crc     <= crc8_step(crc, bus_bit);
                            bit_cnt <= bit_cnt + 3'd1;
                            if (slot_op == OW_BIT_READ && bit_cnt == 3'd7)
                                rd_data <= {bus_bit, shreg[7:1]};
                        end
                        if (last_slot) begin
                            state <= OW_BYTE_IDLE;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                        end else begin
                            state <= OW_BYTE_ISSUE;  // Next slot right away
                        end
                    end
                end
                default: begin
                    state <= OW_BYTE_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // Shift register, payload only
    always_ff @(posedge clk) begin
        if (state == OW_BYTE_IDLE && accept)
            shreg <= cmd_data;
        else if (data_done)
            shreg <= {bus_bit, shreg[7:1]};  // Written byte rotates back in
    end

    // ====================
    // Bit master
    one_wire_master #(
        .CLK_FREQ (CLK_FREQ)
    ) u_bit_master (
        .clk               (clk),
        .rst_n             (rst_n),
        .bit_op            (bit_op),
        .bit_wdata         (bit_wdata),
        .busy              (bit_busy),
        .bit_done          (bit_done),
        .bit_rdata         (bit_rdata),
        .presence_detected (bit_presence),
        .onewire_io        (onewire_io)
    );

    // NOP is the only way to finish straight from idle
    a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(busy) || $past(cmd_valid && cmd_op == OW_CMD_NOP));

endmodule

/* ow_host_top.sv */
// Top of the 1-Wire host subsystem
// Sets the clock frequency for every timer below
// onewire_io needs an external pull-up
module ow_host_top import ow_host_pkg::*; #(
    parameter int CLK_FREQ = 25_000_000  // Hz, whole MHz only
) (
    input  logic       clk,
    input  logic       rst_n,

    // ====================
    // Host command port
    input  logic       cmd_valid,  // Taken when busy is low
    input  ow_cmd_e    cmd_op,
    input  logic [7:0] cmd_data,   // Byte to write
    output logic       busy,
    output logic       done,
    output logic [7:0] rd_data,    // Last byte read
    output logic       presence,   // Result of last reset
    output logic [7:0] crc,        // CRC-8 since last reset

    // ====================
    // Bus pin
    inout  wire        onewire_io
);

    // Byte engine owns the bit master
    ow_byte_engine #(
        .CLK_FREQ (CLK_FREQ)
    ) u_byte_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .busy       (busy),
        .done       (done),
        .rd_data    (rd_data),
        .presence   (presence),
        .crc        (crc),
        .onewire_io (onewire_io)
    );

endmodule

/* ow_slave_model.sv */
// Behavioral 1-Wire slave, simulation only, no ROM or function commands
// Written bytes go into a FIFO and come back LSB first on read slots
// reading must be set before the first read slot of a byte starts
module ow_slave_model import ow_bus_pkg::*; (
    inout wire  onewire_io,
    input logic present,  // Answer resets with a presence pulse
    input logic reading   // Next slots are read slots
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int US            = 1000;
    localparam int RESET_MIN_US  = 400;
    localparam int PRES_START_US = 15;   // After release
    localparam int PRES_END_US   = 135;
    localparam int WR_SAMPLE_US  = 30;
    localparam int RD_HOLD_US    = 2 * (OW_T_READ_LOW_US + OW_T_READ_SAMPLE_US);

    logic       drive_low = 1'b0;
    logic [7:0] fifo [$];
    logic [7:0] wr_byte   = 8'h00;
    int         wr_cnt    = 0;
    int         rd_cnt    = 0;
    logic       sample;
    time        t_fall;

    assign onewire_io = drive_low ? 1'b0 : 1'bz;

    // One pass per falling edge made by the master
    always begin
        @(negedge onewire_io);
        if (onewire_io === 1'b0) begin  // Skip x edges at start-up
            t_fall = $time;
            if (reading) begin
                if (fifo.size() > 0 && !fifo[0][rd_cnt]) begin
                    drive_low = 1'b1;  // Hold past the sample point
                    #(RD_HOLD_US * US);
                    drive_low = 1'b0;
                end
                rd_cnt = rd_cnt + 1;
                if (rd_cnt == 8) begin
                    rd_cnt = 0;
                    if (fifo.size() > 0)
                        void'(fifo.pop_front());
                end
            end else begin
                #(WR_SAMPLE_US * US);
                sample = onewire_io;
                if (onewire_io !== 1'b1)
                    @(posedge onewire_io);
                if ($time - t_fall > RESET_MIN_US * US) begin
                    // Bus reset, drop any partial byte
                    wr_cnt = 0;
                    rd_cnt = 0;
                    if (present) begin
                        #(PRES_START_US * US);
                        drive_low = 1'b1;
                        #((PRES_END_US - PRES_START_US) * US);
                        drive_low = 1'b0;
                    end
                end else begin
                    wr_byte = {sample, wr_byte[7:1]};  // LSB first
                    wr_cnt  = wr_cnt + 1;
                    if (wr_cnt == 8) begin
                        fifo.push_back(wr_byte);
                        wr_cnt = 0;
                    end
                end
            end
        end
    end

endmodule

/* tb_ow_host.sv */
// Testbench for the 1-Wire host controller with a behavioral slave
// Commands and expected results come from ow_tests.txt, run from the project root
// Stops at the first mismatch
module tb_ow_host import ow_host_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_FREQ   = 25_000_000;
    localparam int SLOT_CYC   = 1700;  // One bit slot plus margin
    localparam int LINE_SLOTS = 9;     // Reset is the longest line
    localparam int GAP_CYC    = 750;   // Presence pulse outlasts the reset slot

    logic       clk;
    logic       rst_n;
    logic       cmd_valid;
    ow_cmd_e    cmd_op;
    logic [7:0] cmd_data;
    logic       busy;
    logic       done;
    logic [7:0] rd_data;
    logic       presence;
    logic [7:0] crc;
    wire        onewire_io;
    logic       slave_present;
    logic       slave_reading;

    int         fd;
    int         n_lines;
    int         cycles;
    int         cycle_limit;
    string      line;
    int         op;
    int         data;
    int         expect_v;
    int         present;
    logic [7:0] exp_crc;   // Reference model state
    logic [7:0] exp_rd;
    logic       exp_pres;

    pullup (onewire_io);

    ow_host_top #(
        .CLK_FREQ (CLK_FREQ)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .busy       (busy),
        .done       (done),
        .rd_data    (rd_data),
        .presence   (presence),
        .crc        (crc),
        .onewire_io (onewire_io)
    );

    ow_slave_model slave0 (
        .onewire_io (onewire_io),
        .present    (slave_present),
        .reading    (slave_reading)
    );

    always #20 clk = ~clk;  // 25 MHz

    // ====================
    // Timeout
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, done never came", cycles);
            $display("Test failures found");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // Dallas CRC-8 over one byte, LSB first
    function automatic logic [7:0] crc8_byte(input logic [7:0] c, input logic [7:0] b);
        logic [7:0] r;
        r = c;
        for (int i = 0; i < 8; i++)
            r = (r >> 1) ^ ((r[0] ^ b[i]) ? OW_CRC_POLY : 8'h00);
        return r;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ====================
    // One command from the data file
    task automatic run_line(input ow_cmd_e op_e, input logic [7:0] byte_v,
                            input logic [7:0] expect_b, input logic present_b);
        @(posedge clk);
        #2;
        slave_present = present_b;
        slave_reading = (op_e == OW_CMD_READ_BYTE);
        cmd_valid     = 1'b1;
        cmd_op        = op_e;
        cmd_data      = byte_v;
        @(posedge clk);
        #2;
        if (op_e != OW_CMD_NOP) begin
            check_flag("busy", 1'b1, busy);
            cmd_op   = OW_CMD_WRITE_BYTE;  // Strobe while busy, must be dropped
            cmd_data = ~byte_v;
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b0;
        @(negedge clk);
        while (!done)
            @(negedge clk);
        case (op_e)
            OW_CMD_RESET: begin
                exp_crc  = 8'h00;
                exp_pres = expect_b[0];
            end
            OW_CMD_WRITE_BYTE: exp_crc = crc8_byte(exp_crc, byte_v);
            OW_CMD_READ_BYTE: begin
                exp_rd  = expect_b;
                exp_crc = crc8_byte(exp_crc, expect_b);
            end
            default: ;  // NOP keeps every result
        endcase
        check_byte("rd_data", exp_rd, rd_data);
        check_flag("presence", exp_pres, presence);
        check_byte("crc", exp_crc, crc);
        check_flag("busy", 1'b0, busy);
        repeat (4) begin
            @(negedge clk);
            check_flag("done", 1'b0, done);  // Only one done per command
            check_flag("busy", 1'b0, busy);
        end
        if (op_e == OW_CMD_RESET)
            repeat (GAP_CYC) @(posedge clk);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_op        = OW_CMD_NOP;
        cmd_data      = 8'h00;
        slave_present = 1'b0;
        slave_reading = 1'b0;
        exp_crc       = 8'h00;
        exp_rd        = 8'h00;
        exp_pres      = 1'b0;
        cycles        = 0;
        n_lines       = 0;
        fd = $fopen("ow_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open ow_tests.txt");
            $display("Test failures found");
            $fatal(1, "No data file");
        end
        // Comment lines fail the scan and are not counted
        while ($fgets(line, fd) != 0)
            if ($sscanf(line, "%h %h %h %h", op, data, expect_v, present) == 4)
                n_lines++;
        $fclose(fd);
        cycle_limit = n_lines * LINE_SLOTS * SLOT_CYC;

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_flag("onewire_io", 1'b1, onewire_io);  // Released, pulled up
        check_byte("rd_data", 8'h00, rd_data);
        check_flag("presence", 1'b0, presence);
        check_byte("crc", 8'h00, crc);

        fd = $fopen("ow_tests.txt", "r");
        while ($fgets(line, fd) != 0)
            if ($sscanf(line, "%h %h %h %h", op, data, expect_v, present) == 4)
                run_line(ow_cmd_e'(op[1:0]), data[7:0], expect_v[7:0], present[0]);
        $fclose(fd);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* project.f */
ow_bus_pkg.sv
ow_host_pkg.sv
one_wire_master.sv
ow_byte_engine.sv
ow_host_top.sv
ow_slave_model.sv
tb_ow_host.sv

/* Bender.yml */
package:
  name: ow_host

sources:
  - ow_bus_pkg.sv
  - ow_host_pkg.sv
  - one_wire_master.sv
  - ow_byte_engine.sv
  - ow_host_top.sv
  - target: test
    files:
      - ow_slave_model.sv
      - tb_ow_host.sv

/* ow_tests.txt */
# op data expect present, hex; op 0 reset, 1 write, 2 read, 3 nop
# expect is presence for a reset and the byte for a read, unused otherwise
0 00 01 1
0 00 00 0
0 00 01 1
1 02 00 1
1 1c 00 1
1 b8 00 1
3 00 00 1
1 01 00 1
1 00 00 1
1 00 00 1
1 00 00 1
1 a2 00 1
0 00 01 1
2 00 02 1
2 00 1c 1
2 00 b8 1
2 00 01 1
3 00 00 1
2 00 00 1
2 00 00 1
2 00 00 1
2 00 a2 1
